/* all.f */
logic/acq_cfg_pkg.sv
logic/acq_data_pkg.sv
logic/capture_ctrl.sv
logic/decimator.sv
logic/ram_packer.sv
logic/acq_top.sv
bench/acq_assert.sv
bench/acq_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module acq_tb -o acq_sim

run: compile
	./obj_dir/acq_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/acq_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module acq_tb;

	import acq_cfg_pkg::*;
	import acq_data_pkg::*;

	typedef struct packed {
		settings_word_t settings;
		ram_addr_t      len;
		logic [31:0]    writes;
		irq_word_t      irq;
	} row_t;

	localparam int ROWS = 5;

	// settings, rec_length, expected writes, interrupt after record
	localparam row_t TABLE [ROWS] = '{
		'{32'h0000_0000, 15'd8, 32'd8, 32'h1},	// div 0, unpacked
		'{32'h0000_0004, 15'd6, 32'd6, 32'h1},	// div 2, pick
		'{32'h0000_0106, 15'd5, 32'd5, 32'h1},	// div 3, sum
		'{32'h0000_0800, 15'd9, 32'd9, 32'h1},	// packed, div 0
		'{32'h0000_2002, 15'd4, 32'd4, 32'hF}	// self irq, div 1
	};

	logic           adc_clkinp;
	logic           ADC_RESET;
	adc_frame_t     adc_frame;
	logic           tx_trig;
	logic           state_reset;
	ram_addr_t      rec_length;
	settings_word_t pio_settings;
	logic           trig_ack;
	irq_word_t      rcv_interrupt;
	ram_port_t      ram;

	logic [31:0]    rng;
	adc_frame_t     next_f;
	int             errors;
	int             writes;
	ram_word_t      exp_q[$];

	// reference model state
	logic [3:0]     m_div;
	logic           m_sum;
	logic           m_pack;
	int             m_cnt;
	logic [15:0]    m_acc [NUM_LANES];
	int             m_slot;
	logic [383:0]   m_grp;

	acq_top dut_i (
		.adc_clkinp    (adc_clkinp),
		.ADC_RESET     (ADC_RESET),
		.adc_frame     (adc_frame),
		.tx_trig       (tx_trig),
		.state_reset   (state_reset),
		.rec_length    (rec_length),
		.pio_settings  (pio_settings),
		.trig_ack      (trig_ack),
		.rcv_interrupt (rcv_interrupt),
		.ram           (ram)
	);

	bind acq_top acq_assert assert_i (
		.adc_clkinp  (adc_clkinp),
		.ADC_RESET   (ADC_RESET),
		.state_reset (state_reset),
		.trig_ack    (trig_ack),
		.ram         (ram)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// one decimated frame into the expected word queue
	task automatic emit_frame(input logic [15:0] v [NUM_LANES]);
		ram_word_t   w;
		logic [95:0] pf;
		if (!m_pack)
		begin
			for (int i = 0; i < NUM_LANES; i++)
				w[i*16 +: 16] = v[i];
			exp_q.push_back(w);
		end
		else
		begin
			for (int i = 0; i < NUM_LANES; i++)
				pf[i*12 +: 12] = v[i][11:0];
			m_grp[m_slot*96 +: 96] = pf;
			if (m_slot == 1)
				exp_q.push_back(m_grp[127:0]);
			else if (m_slot == 2)
				exp_q.push_back(m_grp[255:128]);
			else if (m_slot == 3)
				exp_q.push_back(m_grp[383:256]);
			m_slot = (m_slot + 1) % 4;
		end
	endtask

	task automatic consume_frame(input adc_frame_t f);
		logic [15:0] v [NUM_LANES];
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (m_sum && m_cnt != 0)
				v[i] = m_acc[i] + {4'h0, f[i]};
			else
				v[i] = {4'h0, f[i]};
			m_acc[i] = v[i];
		end
		if (m_cnt == int'(m_div))
		begin
			m_cnt = 0;
			emit_frame(v);
		end
		else
			m_cnt++;
	endtask

	initial
	begin
		adc_clkinp = 1'b0;
		forever #10 adc_clkinp = ~adc_clkinp;
	end

	always @(posedge adc_clkinp)
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			rng = xorshift(rng);
			next_f[i] = rng[11:0];
		end
		adc_frame <= next_f;
	end

	// model and write checks, away from the driving edge
	always @(negedge adc_clkinp)
	begin
		if (!ADC_RESET)
		begin
			if (trig_ack)
				consume_frame(adc_frame);
			else
			begin
				m_cnt = 0;
				m_slot = 0;
				m_grp = '0;
			end
			if (ram.wren)
			begin
				if (exp_q.size() == 0)
				begin
					$display("a RAM write came with no expected word left");
					$display("Simulation FAILED");
					$fatal(1);
				end
				check_value("ram.addr", 128'(ram.addr), 128'(writes));
				check_value("ram.byteen", 128'(ram.byteen), 128'(16'hFFFF));
				check_value("ram.data", ram.data, exp_q.pop_front());
				writes++;
			end
		end
	end

	initial
	begin
		int  max_len;
		longint limit;
		max_len = 0;
		for (int r = 0; r < ROWS; r++)
			if (int'(TABLE[r].len) > max_len)
				max_len = int'(TABLE[r].len);
		limit = longint'(ROWS) * (max_len * 4 * 16 + 50) * 20;
		#(limit);
		$display("timeout: the run did not finish in %0d ns", limit);
		$display("Simulation FAILED");
		$fatal(1);
	end

	task automatic run_row(input int r);
		irq_word_t idle_irq;
		idle_irq = TABLE[r].settings[13] ? 32'hF : 32'h0;
		@(posedge adc_clkinp);
		state_reset <= 1'b1;
		pio_settings <= TABLE[r].settings;
		rec_length <= TABLE[r].len;
		repeat (3) @(posedge adc_clkinp);
		@(negedge adc_clkinp);
		check_value("trig_ack", 128'(trig_ack), 128'(0));
		check_value("ram.clken", 128'(ram.clken), 128'(0));
		check_value("ram.chipsel", 128'(ram.chipsel), 128'(0));
		check_value("ram.byteen", 128'(ram.byteen), 128'(0));
		check_value("ram.wren", 128'(ram.wren), 128'(0));
		check_value("rcv_interrupt", 128'(rcv_interrupt), 128'(idle_irq));
		m_div = TABLE[r].settings[4:1];
		m_sum = (TABLE[r].settings[10:8] == 3'd1);
		m_pack = |TABLE[r].settings[12:11];
		exp_q.delete();
		writes = 0;
		@(posedge adc_clkinp);
		state_reset <= 1'b0;
		tx_trig <= 1'b1;
		@(posedge adc_clkinp);
		tx_trig <= 1'b0;
		while (!trig_ack)
			@(negedge adc_clkinp);
		while (trig_ack)
			@(negedge adc_clkinp);
		check_value("write count", 128'(writes), 128'(TABLE[r].writes));
		check_value("rcv_interrupt", 128'(rcv_interrupt), 128'(TABLE[r].irq));
		// a late trigger must not start another record
		@(posedge adc_clkinp);
		tx_trig <= 1'b1;
		@(posedge adc_clkinp);
		tx_trig <= 1'b0;
		repeat (10) @(negedge adc_clkinp);
		check_value("trig_ack", 128'(trig_ack), 128'(0));
		check_value("write count", 128'(writes), 128'(TABLE[r].writes));
	endtask

	initial
	begin
		ADC_RESET = 1'b1;
		adc_frame = '0;
		tx_trig = 1'b0;
		state_reset = 1'b0;
		rec_length = '0;
		pio_settings = '0;
		rng = 32'h76c1;
		errors = 0;
		writes = 0;
		m_div = '0;
		m_sum = 1'b0;
		m_pack = 1'b0;
		m_cnt = 0;
		m_slot = 0;
		m_grp = '0;
		repeat (5) @(posedge adc_clkinp);
		ADC_RESET <= 1'b0;
		@(negedge adc_clkinp);
		check_value("trig_ack", 128'(trig_ack), 128'(0));
		check_value("ram.clken", 128'(ram.clken), 128'(0));
		check_value("ram.chipsel", 128'(ram.chipsel), 128'(0));
		check_value("ram.byteen", 128'(ram.byteen), 128'(0));
		check_value("ram.wren", 128'(ram.wren), 128'(0));
		check_value("rcv_interrupt", 128'(rcv_interrupt), 128'(0));
		for (int r = 0; r < ROWS; r++)
			run_row(r);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/acq_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module acq_assert (
	input logic                    adc_clkinp,
	input logic                    ADC_RESET,
	input logic                    state_reset,
	input logic                    trig_ack,
	input acq_data_pkg::ram_port_t ram
);

	import acq_data_pkg::*;

	ram_addr_t last_addr;
	logic      have_prev;	// a write already seen in this record

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET || !trig_ack)
		begin
			have_prev <= 1'b0;
			last_addr <= '0;
		end
		else if (ram.wren)
		begin
			have_prev <= 1'b1;
			last_addr <= ram.addr;
		end
	end

	wren_needs_enables: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		ram.wren |-> ram.clken && ram.chipsel)
		else $error("wren without clken or chipsel");

	// one cycle for the capture state to drop
	no_ack_in_state_reset: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		state_reset && $past(state_reset) |-> !trig_ack)
		else $error("trig_ack high while state_reset held");

	addr_steps_by_one: assert property (@(posedge adc_clkinp) disable iff (ADC_RESET)
		ram.wren && have_prev |-> ram.addr == last_addr + 1'b1)
		else $error("write address did not step by one");

endmodule

`default_nettype wire

/* logic/acq_top.sv */
`timescale 1ns/1ns
`default_nettype none

module acq_top (
	input  logic                       adc_clkinp,
	input  logic                       ADC_RESET,
	input  acq_data_pkg::adc_frame_t    adc_frame,
	input  logic                       tx_trig,
	input  logic                       state_reset,
	input  acq_data_pkg::ram_addr_t     rec_length,
	input  acq_cfg_pkg::settings_word_t pio_settings,
	output logic                       trig_ack,
	output acq_cfg_pkg::irq_word_t      rcv_interrupt,
	output acq_data_pkg::ram_port_t     ram
);

	import acq_cfg_pkg::*;
	import acq_data_pkg::*;

	acq_settings_t settings;
	frame_t        frame_out;
	logic          frame_strobe;
	logic          record_done;

	// trig_ack doubles as the armed level
	capture_ctrl ctrl_i (
		.adc_clkinp    (adc_clkinp),
		.ADC_RESET     (ADC_RESET),
		.tx_trig       (tx_trig),
		.state_reset   (state_reset),
		.pio_settings  (pio_settings),
		.record_done   (record_done),
		.settings      (settings),
		.armed         (trig_ack),
		.rcv_interrupt (rcv_interrupt)
	);

	decimator dec_i (
		.adc_clkinp   (adc_clkinp),
		.ADC_RESET    (ADC_RESET),
		.armed        (trig_ack),
		.settings     (settings),
		.adc_frame    (adc_frame),
		.frame_out    (frame_out),
		.frame_strobe (frame_strobe)
	);

	ram_packer pack_i (
		.adc_clkinp   (adc_clkinp),
		.ADC_RESET    (ADC_RESET),
		.armed        (trig_ack),
		.settings     (settings),
		.rec_length   (rec_length),
		.frame_out    (frame_out),
		.frame_strobe (frame_strobe),
		.ram          (ram),
		.record_done  (record_done)
	);

endmodule

`default_nettype wire

/* logic/ram_packer.sv */
`timescale 1ns/1ns
`default_nettype none

module ram_packer (
	input  logic                      adc_clkinp,
	input  logic                      ADC_RESET,
	input  logic                      armed,
	input  acq_cfg_pkg::acq_settings_t settings,
	input  acq_data_pkg::ram_addr_t    rec_length,
	input  acq_data_pkg::frame_t       frame_out,
	input  logic                      frame_strobe,
	output acq_data_pkg::ram_port_t    ram,
	output logic                      record_done
);

	import acq_cfg_pkg::*;
	import acq_data_pkg::*;

	logic [1:0]        phase;		// frame slot within group of four
	ram_addr_t         addr_cnt;
	logic [PACK_W-1:0] pf;			// current frame, 12-bit dense
	logic [PACK_W-1:0] pack_buf;	// leftover bits of earlier frames
	ram_word_t         wdata;
	logic              accept;
	logic              wr_en;
	logic              addr_last;

	logic              wren_q;
	ram_addr_t         addr_q;
	ram_word_t         data_q;

	// frames arriving during the final write are dropped
	assign accept = armed && frame_strobe && !record_done;
	assign wr_en = accept && (!settings.pack_en || phase != 2'd0);

	assign addr_last = (addr_cnt == ram_addr_t'(rec_length - 1'b1)) || (addr_cnt == ADDR_MAX);

	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
			pf[i*SAMPLE_W +: SAMPLE_W] = frame_out[i][SAMPLE_W-1:0];
	end

	// 384 bits per four frames, oldest lowest
	always_comb
	begin
		if (!settings.pack_en)
		begin
			wdata = frame_out;
		end
		else
		begin
			case (phase)
				2'd1:    wdata = {pf[31:0], pack_buf};
				2'd2:    wdata = {pf[63:0], pack_buf[63:0]};
				default: wdata = {pf, pack_buf[31:0]};
			endcase
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
		begin
			phase <= 2'd0;
			addr_cnt <= '0;
			pack_buf <= '0;
			wren_q <= 1'b0;
			addr_q <= '0;
			data_q <= '0;
			record_done <= 1'b0;
		end
		else if (!armed)
		begin
			phase <= 2'd0;
			addr_cnt <= '0;
			pack_buf <= '0;
			wren_q <= 1'b0;
			record_done <= 1'b0;
		end
		else
		begin
			wren_q <= wr_en;
			record_done <= wr_en && addr_last;
			if (wr_en)
			begin
				addr_q <= addr_cnt;
				data_q <= wdata;
				addr_cnt <= addr_cnt + 1'b1;
			end
			if (accept && settings.pack_en)
			begin
				phase <= phase + 1'b1;
				case (phase)
					2'd0:    pack_buf <= pf;
					2'd1:    pack_buf <= PACK_W'(pf[95:32]);	// 64 bits left over
					2'd2:    pack_buf <= PACK_W'(pf[95:64]);
					default: pack_buf <= '0;	// group complete
				endcase
			end
		end
	end

	always_comb
	begin
		ram.wren = wren_q && armed;
		ram.clken = armed;
		ram.chipsel = armed;
		ram.byteen = {$bits(byte_en_t){armed}};
		ram.addr = addr_q;
		ram.data = data_q;
	end

endmodule

`default_nettype wire

/* logic/decimator.sv */
`timescale 1ns/1ns
`default_nettype none

module decimator (
	input  logic                      adc_clkinp,
	input  logic                      ADC_RESET,
	input  logic                      armed,
	input  acq_cfg_pkg::acq_settings_t settings,
	input  acq_data_pkg::adc_frame_t   adc_frame,
	output acq_data_pkg::frame_t       frame_out,
	output logic                      frame_strobe
);

	import acq_cfg_pkg::*;
	import acq_data_pkg::*;

	frame_t   ext;		// samples widened to lanes
	frame_t   acc;
	frame_t   win_val;
	divisor_t cnt;		// position in window
	logic     win_last;

	assign win_last = (cnt == settings.divisor);

	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			ext[i] = {{(LANE_W - SAMPLE_W){1'b0}}, adc_frame[i]};
			// first frame of a window restarts the sum
			if (settings.mode == SAMP_SUM && cnt != '0)
				win_val[i] = acc[i] + ext[i];
			else
				win_val[i] = ext[i];
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
		begin
			cnt <= '0;
			acc <= '0;
			frame_out <= '0;
			frame_strobe <= 1'b0;
		end
		else if (!armed)
		begin
			cnt <= '0;
			acc <= '0;
			frame_strobe <= 1'b0;
		end
		else
		begin
			acc <= win_val;
			frame_strobe <= win_last;
			if (win_last)
			begin
				cnt <= '0;
				frame_out <= win_val;	// pick or sum result
			end
			else
			begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/capture_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module capture_ctrl (
	input  logic                       adc_clkinp,
	input  logic                       ADC_RESET,
	input  logic                       tx_trig,
	input  logic                       state_reset,
	input  acq_cfg_pkg::settings_word_t pio_settings,
	input  logic                       record_done,
	output acq_cfg_pkg::acq_settings_t  settings,
	output logic                       armed,
	output acq_cfg_pkg::irq_word_t      rcv_interrupt
);

	import acq_cfg_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,	// waiting for trigger
		ST_ARMED,
		ST_DONE		// record finished, wait for state_reset
	} cap_state_e;

	cap_state_e state;

	function automatic acq_settings_t decode_settings(input settings_word_t word);
		acq_settings_t        s;
		logic [MODE_W-1:0]    mode_raw;
		s.divisor = word[DIV_LSB +: $bits(divisor_t)];
		mode_raw = word[MODE_LSB +: MODE_W];
		// unknown codes fall back to pick
		s.mode = (mode_raw == MODE_W'(SAMP_SUM)) ? SAMP_SUM : SAMP_PICK;
		s.pack_en = |word[COMP_LSB +: COMP_W];
		s.self_irq = word[SELF_IRQ_BIT];
		return s;
	endfunction

	assign armed = (state == ST_ARMED);

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
		begin
			settings <= '0;
			state <= ST_IDLE;
			rcv_interrupt <= '0;
		end
		else if (state_reset)
		begin
			settings <= decode_settings(pio_settings);
			state <= ST_IDLE;
			rcv_interrupt <= settings.self_irq ? IRQ_SELF_VALUE : '0;	// uses latched bit
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (tx_trig)
						state <= ST_ARMED;
				end
				ST_ARMED:
				begin
					if (record_done)
					begin
						state <= ST_DONE;
						rcv_interrupt[0] <= 1'b1;
					end
				end
				default:
				begin
					state <= ST_DONE;	// one record per release
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/acq_data_pkg.sv */
`default_nettype none

package acq_data_pkg;

	localparam int NUM_LANES = 8;
	localparam int SAMPLE_W  = 12;
	localparam int LANE_W    = 16;

	// one frame in dense 12-bit form
	localparam int PACK_W = NUM_LANES * SAMPLE_W;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// zero-extended sample or lane sum
	typedef logic [LANE_W-1:0] lane_t;

	// lane 0 sits in the low bits
	typedef lane_t [NUM_LANES-1:0] frame_t;
	typedef sample_t [NUM_LANES-1:0] adc_frame_t;

	typedef logic [127:0] ram_word_t;

	// top bit marks overrun
	typedef logic [14:0] ram_addr_t;

	// highest address before overrun
	localparam ram_addr_t ADDR_MAX = 15'h3FFF;

	typedef logic [15:0] byte_en_t;

	typedef struct packed {
		logic      wren;
		logic      clken;
		logic      chipsel;
		byte_en_t  byteen;
		ram_addr_t addr;
		ram_word_t data;
	} ram_port_t;

endpackage

`default_nettype wire

/* logic/acq_cfg_pkg.sv */
`default_nettype none

package acq_cfg_pkg;

	// raw settings bus as written by the host
	typedef logic [31:0] settings_word_t;

	// field positions in the settings word
	localparam int DIV_LSB      = 1;	// divisor, 4 bits
	localparam int MODE_LSB     = 8;	// sampling mode, 3 bits
	localparam int COMP_LSB     = 11;	// compressor, 2 bits
	localparam int SELF_IRQ_BIT = 13;

	localparam int MODE_W = 3;
	localparam int COMP_W = 2;

	// window holds divisor+1 frames
	typedef logic [3:0] divisor_t;

	typedef enum logic [2:0] {
		SAMP_PICK = 3'd0,	// last frame of window
		SAMP_SUM  = 3'd1	// lane-wise running sum
	} samp_mode_e;

	typedef struct packed {
		divisor_t   divisor;
		samp_mode_e mode;
		logic       pack_en;	// any compressor bit set
		logic       self_irq;
	} acq_settings_t;

	typedef logic [31:0] irq_word_t;

	localparam irq_word_t IRQ_SELF_VALUE = 32'hF;

endpackage

`default_nettype wire
